/* Makefile */
VERILATOR  := verilator
TOP        := exec_unit_tb
FILE_LIST  := src.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
SIM_LOG    := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "$(FAIL_MSG)" $(SIM_LOG); then \
		echo "Test FAILED, see $(SIM_LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(SIM_LOG); then \
		echo "Run ended early, see $(SIM_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

/* logic/alu.sv */
module alu (
    input  exec_pkg::alu_op_e         alu_op,
    input  exec_pkg::br_op_e          br_op,
    input  exec_pkg::sign_e           sign_sel,
    input  logic [exec_pkg::XLEN-1:0] op1,
    input  logic [exec_pkg::XLEN-1:0] op2,
    output logic [exec_pkg::XLEN-1:0] alu_out,
    output logic                      branch_take
);
    import exec_pkg::*;

    function automatic logic less_than(
        input sign_e           sgn,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        if (sgn == OP_SIGNED) begin
            less_than = $signed(a) < $signed(b);
        end else begin
            less_than = a < b;
        end
    endfunction

    function automatic logic [XLEN-1:0] alu_calc(
        input alu_op_e         fun,
        input sign_e           sgn,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] sum;
        sum = a + b;
        case (fun)
            ALU_ADD:      alu_calc = sum;
            ALU_SUB:      alu_calc = a - b;
            ALU_AND:      alu_calc = a & b;
            ALU_OR:       alu_calc = a | b;
            ALU_XOR:      alu_calc = a ^ b;
            ALU_SLL:      alu_calc = a << b[4:0];
            ALU_SRL:      alu_calc = a >> b[4:0];
            ALU_SRA:      alu_calc = $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:      alu_calc = {{(XLEN-1){1'b0}}, less_than(sgn, a, b)};
            // Target address, low bit dropped
            ALU_JALR:     alu_calc = {sum[XLEN-1:1], 1'b0};
            ALU_COPY1:    alu_calc = a;
            ALU_CZERO_EQ: alu_calc = (b == '0) ? '0 : a;
            ALU_CZERO_NE: alu_calc = (b != '0) ? '0 : a;
            default:      alu_calc = '0;
        endcase
    endfunction

    function automatic logic br_calc(
        input br_op_e          fun,
        input sign_e           sgn,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (fun)
            BR_BEQ:  br_calc = (a == b);
            BR_BNE:  br_calc = (a != b);
            BR_BLT:  br_calc = less_than(sgn, a, b);
            BR_BGE:  br_calc = !less_than(sgn, a, b);
            default: br_calc = 1'b0;
        endcase
    endfunction

    assign alu_out     = alu_calc(alu_op, sign_sel, op1, op2);
    assign branch_take = br_calc(br_op, sign_sel, op1, op2);

endmodule

/* logic/exec_pkg.sv */
package exec_pkg;

    // Data and pc width
    localparam int XLEN = 32;

    // Sequential pc increment
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // Major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_JALR,
        ALU_COPY1,
        ALU_CZERO_EQ,
        ALU_CZERO_NE
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE
    } br_op_e;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_e;

    // Control flow class, picks the next pc rule
    typedef enum logic [1:0] {
        CTL_SEQ,
        CTL_BRANCH,
        CTL_JAL,
        CTL_JALR
    } ctl_kind_e;

endpackage

/* logic/exec_result.sv */
module exec_result (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      d_valid,
    output logic                      d_ready,
    input  logic [exec_pkg::XLEN-1:0] alu_out,
    input  logic                      branch_take,
    input  logic [exec_pkg::XLEN-1:0] d_pc,
    input  logic [exec_pkg::XLEN-1:0] imm,
    input  logic [4:0]                rd_addr,
    input  logic                      rd_write,
    input  exec_pkg::ctl_kind_e       ctl_kind,
    input  logic                      illegal,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [4:0]                out_rd_addr,
    output logic                      out_rd_write,
    output logic [exec_pkg::XLEN-1:0] rd_data,
    output logic                      branch_taken,
    output logic [exec_pkg::XLEN-1:0] next_pc,
    output logic                      out_illegal
);
    import exec_pkg::*;

    logic [XLEN-1:0] pc_seq;
    logic [XLEN-1:0] pc_tgt;
    logic [XLEN-1:0] data_c;
    logic [XLEN-1:0] next_c;
    logic            taken_c;
    logic            load;

    assign pc_seq = d_pc + PC_STEP;
    assign pc_tgt = d_pc + imm;

    always_comb begin
        data_c  = alu_out;
        next_c  = pc_seq;
        taken_c = 1'b0;
        case (ctl_kind)
            CTL_JAL: begin
                data_c  = pc_seq;
                next_c  = pc_tgt;
                taken_c = 1'b1;
            end
            CTL_JALR: begin
                data_c  = pc_seq;
                next_c  = alu_out;
                taken_c = 1'b1;
            end
            CTL_BRANCH: begin
                taken_c = branch_take;
                next_c  = branch_take ? pc_tgt : pc_seq;
            end
            default: ;
        endcase
    end

    // Slot frees when empty or draining this cycle
    assign d_ready = !out_valid || out_ready;
    assign load    = d_valid && d_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (d_ready) begin
            out_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_rd_addr  <= rd_addr;
            out_rd_write <= rd_write;
            rd_data      <= data_c;
            branch_taken <= taken_c;
            next_pc      <= next_c;
            out_illegal  <= illegal;
        end
    end

endmodule

/* logic/exec_unit.sv */
module exec_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [31:0]               instr,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [4:0]                rd_addr,
    output logic                      rd_write,
    output logic [exec_pkg::XLEN-1:0] rd_data,
    output logic                      branch_taken,
    output logic [exec_pkg::XLEN-1:0] next_pc,
    output logic                      illegal
);
    import exec_pkg::*;

    // Decode stage registers
    logic            d_valid;
    logic            d_ready;
    alu_op_e         d_alu_op;
    br_op_e          d_br_op;
    sign_e           d_sign_sel;
    logic [XLEN-1:0] d_op1;
    logic [XLEN-1:0] d_op2;
    logic [XLEN-1:0] d_imm;
    logic [XLEN-1:0] d_pc;
    logic [4:0]      d_rd_addr;
    logic            d_rd_write;
    ctl_kind_e       d_ctl_kind;
    logic            d_illegal;

    logic [XLEN-1:0] alu_out;
    logic            branch_take;

    rv_decode i_rv_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .alu_op   (d_alu_op),
        .br_op    (d_br_op),
        .sign_sel (d_sign_sel),
        .op1      (d_op1),
        .op2      (d_op2),
        .imm      (d_imm),
        .d_pc     (d_pc),
        .rd_addr  (d_rd_addr),
        .rd_write (d_rd_write),
        .ctl_kind (d_ctl_kind),
        .illegal  (d_illegal)
    );

    alu i_alu (
        .alu_op      (d_alu_op),
        .br_op       (d_br_op),
        .sign_sel    (d_sign_sel),
        .op1         (d_op1),
        .op2         (d_op2),
        .alu_out     (alu_out),
        .branch_take (branch_take)
    );

    exec_result i_exec_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .alu_out      (alu_out),
        .branch_take  (branch_take),
        .d_pc         (d_pc),
        .imm          (d_imm),
        .rd_addr      (d_rd_addr),
        .rd_write     (d_rd_write),
        .ctl_kind     (d_ctl_kind),
        .illegal      (d_illegal),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rd_addr  (rd_addr),
        .out_rd_write (rd_write),
        .rd_data      (rd_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc),
        .out_illegal  (illegal)
    );

endmodule

/* logic/rv_decode.sv */
module rv_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [31:0]               instr,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    output logic                      d_valid,
    input  logic                      d_ready,
    output exec_pkg::alu_op_e         alu_op,
    output exec_pkg::br_op_e          br_op,
    output exec_pkg::sign_e           sign_sel,
    output logic [exec_pkg::XLEN-1:0] op1,
    output logic [exec_pkg::XLEN-1:0] op2,
    output logic [exec_pkg::XLEN-1:0] imm,
    output logic [exec_pkg::XLEN-1:0] d_pc,
    output logic [4:0]                rd_addr,
    output logic                      rd_write,
    output exec_pkg::ctl_kind_e       ctl_kind,
    output logic                      illegal
);
    import exec_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    alu_op_e         alu_op_c;
    br_op_e          br_op_c;
    sign_e           sign_c;
    logic [XLEN-1:0] op1_c;
    logic [XLEN-1:0] op2_c;
    logic [XLEN-1:0] imm_c;
    logic            rd_write_c;
    ctl_kind_e       ctl_c;
    logic            illegal_c;
    logic            accept;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op_c   = ALU_ADD;
        br_op_c    = BR_NONE;
        sign_c     = OP_SIGNED;
        op1_c      = rs1_data;
        op2_c      = rs2_data;
        imm_c      = imm_i;
        rd_write_c = 1'b1;
        ctl_c      = CTL_SEQ;
        illegal_c  = 1'b0;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_op_c = ALU_ADD;
                    10'b0100000_000: alu_op_c = ALU_SUB;
                    10'b0000000_001: alu_op_c = ALU_SLL;
                    10'b0000000_010: alu_op_c = ALU_SLT;
                    10'b0000000_011: begin
                        alu_op_c = ALU_SLT;
                        sign_c   = OP_UNSIGNED;
                    end
                    10'b0000000_100: alu_op_c = ALU_XOR;
                    10'b0000000_101: alu_op_c = ALU_SRL;
                    10'b0100000_101: alu_op_c = ALU_SRA;
                    10'b0000000_110: alu_op_c = ALU_OR;
                    10'b0000000_111: alu_op_c = ALU_AND;
                    // Zicond
                    10'b0000111_101: alu_op_c = ALU_CZERO_EQ;
                    10'b0000111_111: alu_op_c = ALU_CZERO_NE;
                    default:         illegal_c = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                op2_c = imm_i;
                case (funct3)
                    3'd0: alu_op_c = ALU_ADD;
                    3'd2: alu_op_c = ALU_SLT;
                    3'd3: begin
                        alu_op_c = ALU_SLT;
                        sign_c   = OP_UNSIGNED;
                    end
                    3'd4: alu_op_c = ALU_XOR;
                    3'd6: alu_op_c = ALU_OR;
                    3'd7: alu_op_c = ALU_AND;
                    3'd1: begin
                        alu_op_c  = ALU_SLL;
                        illegal_c = (funct7 != 7'b0000000);
                    end
                    default: begin
                        // funct3 5, shift right by immediate
                        alu_op_c  = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
                        illegal_c = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            OPC_LUI: begin
                op1_c = '0;
                op2_c = imm_u;
            end
            OPC_AUIPC: begin
                op1_c = pc;
                op2_c = imm_u;
            end
            OPC_JAL: begin
                imm_c = imm_j;
                ctl_c = CTL_JAL;
            end
            OPC_JALR: begin
                alu_op_c  = ALU_JALR;
                op2_c     = imm_i;
                ctl_c     = CTL_JALR;
                illegal_c = (funct3 != 3'd0);
            end
            OPC_BRANCH: begin
                imm_c      = imm_b;
                ctl_c      = CTL_BRANCH;
                rd_write_c = 1'b0;
                sign_c     = funct3[1] ? OP_UNSIGNED : OP_SIGNED;
                case (funct3)
                    3'd0:    br_op_c = BR_BEQ;
                    3'd1:    br_op_c = BR_BNE;
                    3'd4:    br_op_c = BR_BLT;
                    3'd5:    br_op_c = BR_BGE;
                    3'd6:    br_op_c = BR_BLT;
                    3'd7:    br_op_c = BR_BGE;
                    default: illegal_c = 1'b1;
                endcase
            end
            default: illegal_c = 1'b1;
        endcase

        // Illegal words behave as a no-op that steps the pc
        if (illegal_c) begin
            br_op_c = BR_NONE;
            ctl_c   = CTL_SEQ;
        end
        if (illegal_c || instr[11:7] == 5'd0) begin
            rd_write_c = 1'b0;
        end
    end

    assign in_ready = !d_valid || d_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d_valid <= 1'b0;
        end else if (in_ready) begin
            d_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op   <= alu_op_c;
            br_op    <= br_op_c;
            sign_sel <= sign_c;
            op1      <= op1_c;
            op2      <= op2_c;
            imm      <= imm_c;
            d_pc     <= pc;
            rd_addr  <= instr[11:7];
            rd_write <= rd_write_c;
            ctl_kind <= ctl_c;
            illegal  <= illegal_c;
        end
    end

endmodule

/* src.f */
logic/exec_pkg.sv
logic/alu.sv
logic/rv_decode.sv
logic/exec_result.sv
logic/exec_unit.sv
tests/exec_unit_properties.sv
tests/exec_unit_tb.sv

/* tests/exec_unit_properties.sv */
module exec_unit_properties (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      in_ready,
    input logic                      d_valid,
    input logic                      d_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input logic [4:0]                rd_addr,
    input logic                      rd_write,
    input logic [exec_pkg::XLEN-1:0] rd_data,
    input logic                      branch_taken,
    input logic [exec_pkg::XLEN-1:0] next_pc,
    input logic                      illegal
);

    // Pipeline comes out of reset empty
    out_empty_after_reset: assert property (@(posedge clk) !arst_n |=> !out_valid)
        else $error("out_valid high right after reset");

    // Stalled output holds
    out_hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(rd_addr) && $stable(rd_write)
            && $stable(rd_data) && $stable(branch_taken) && $stable(next_pc)
            && $stable(illegal))
        else $error("output changed while stalled");

    in_ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (!d_valid || d_ready))
        else $error("in_ready does not follow the decode stage state");

endmodule

/* tests/exec_unit_tb.sv */
module exec_unit_tb;
    import exec_pkg::*;

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 16;
    localparam int          NUM_INSTR     = 2000;
    // Back-pressure stops after this many instructions
    localparam int          BP_INSTR      = 1600;
    localparam logic [31:0] SEED          = 32'hcea32682;
    localparam int          WATCHDOG_TIME = NUM_INSTR * 4 * CLK_PERIOD
                                            + RESET_CYCLES * CLK_PERIOD;

    typedef struct packed {
        logic [4:0]      rd_addr;
        logic            rd_write;
        logic [XLEN-1:0] rd_data;
        logic            branch_taken;
        logic [XLEN-1:0] next_pc;
        logic            illegal;
    } result_t;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            in_valid;
    logic            in_ready;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            out_valid;
    logic            out_ready;
    logic [4:0]      rd_addr;
    logic            rd_write;
    logic [XLEN-1:0] rd_data;
    logic            branch_taken;
    logic [XLEN-1:0] next_pc;
    logic            illegal;

    result_t exp_q[$];
    int      edge_q[$];
    int      edge_count    = 0;
    int      last_low_edge = 0;
    int      issued        = 0;
    logic    offer_taken   = 1'b0;

    exec_unit i_exec_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .rd_addr      (rd_addr),
        .rd_write     (rd_write),
        .rd_data      (rd_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc),
        .illegal      (illegal)
    );

    bind exec_unit exec_unit_properties i_properties (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_ready     (in_ready),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .rd_addr      (rd_addr),
        .rd_write     (rd_write),
        .rd_data      (rd_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc),
        .illegal      (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("MISMATCH at time %0t: %s expected %h, got %h", $time, name, want, got);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, why);
    endtask

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got == want)
            else report_mismatch(name, want, got);
    endtask

    // Integer ops shared by OP and OP-IMM, alt selects sub and sra
    function automatic logic [XLEN-1:0] arith_result(
        input logic [2:0]      f3,
        input logic            alt,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (f3)
            3'd0: arith_result = alt ? a - b : a + b;
            3'd1: arith_result = a << b[4:0];
            3'd2: arith_result = {31'd0, $signed(a) < $signed(b)};
            3'd3: arith_result = {31'd0, a < b};
            3'd4: arith_result = a ^ b;
            3'd5: begin
                arith_result = a >> b[4:0];
                if (alt && a[31]) begin
                    arith_result = arith_result | ~(32'hffff_ffff >> b[4:0]);
                end
            end
            3'd6: arith_result = a | b;
            default: arith_result = a & b;
        endcase
    endfunction

    function automatic result_t ref_exec(
        input logic [31:0]     word,
        input logic [XLEN-1:0] cur_pc,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        result_t         r;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic            bad;
        logic            is_branch;
        logic            cond;

        f3    = word[14:12];
        f7    = word[31:25];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_u = {word[31:12], 12'h000};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

        r.rd_addr      = word[11:7];
        r.rd_data      = '0;
        r.branch_taken = 1'b0;
        r.next_pc      = cur_pc + 32'd4;
        bad            = 1'b0;
        is_branch      = 1'b0;
        cond           = 1'b0;
        case (word[6:0])
            OPC_OP: begin
                if (f7 == 7'b0000000) begin
                    r.rd_data = arith_result(f3, 1'b0, a, b);
                end else if (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5)) begin
                    r.rd_data = arith_result(f3, 1'b1, a, b);
                end else if (f7 == 7'b0000111 && f3 == 3'd5) begin
                    // czero.eqz
                    r.rd_data = (b == '0) ? '0 : a;
                end else if (f7 == 7'b0000111 && f3 == 3'd7) begin
                    r.rd_data = (b != '0) ? '0 : a;
                end else begin
                    bad = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1 && f7 != 7'b0000000) begin
                    bad = 1'b1;
                end
                if (f3 == 3'd5 && f7 != 7'b0000000 && f7 != 7'b0100000) begin
                    bad = 1'b1;
                end
                r.rd_data = arith_result(f3, f3 == 3'd5 && f7 == 7'b0100000, a, imm_i);
            end
            OPC_LUI:   r.rd_data = imm_u;
            OPC_AUIPC: r.rd_data = cur_pc + imm_u;
            OPC_JAL: begin
                r.rd_data      = cur_pc + 32'd4;
                r.next_pc      = cur_pc + imm_j;
                r.branch_taken = 1'b1;
            end
            OPC_JALR: begin
                bad            = (f3 != 3'd0);
                r.rd_data      = cur_pc + 32'd4;
                r.next_pc      = (a + imm_i) & 32'hffff_fffe;
                r.branch_taken = 1'b1;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                case (f3)
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = $signed(a) < $signed(b);
                    3'd5:    cond = $signed(a) >= $signed(b);
                    3'd6:    cond = a < b;
                    3'd7:    cond = a >= b;
                    default: bad = 1'b1;
                endcase
                r.branch_taken = cond;
                if (cond) begin
                    r.next_pc = cur_pc + imm_b;
                end
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            r.branch_taken = 1'b0;
            r.next_pc      = cur_pc + 32'd4;
        end
        r.rd_write = !bad && !is_branch && (word[11:7] != 5'd0);
        r.illegal  = bad;
        return r;
    endfunction

    // Kinds 0..7 are legal classes, anything else a raw random word
    function automatic logic [31:0] build_instr(input int unsigned kind);
        logic [31:0] w;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;

        w     = $urandom;
        rd    = ($urandom % 8 == 0) ? 5'd0 : w[11:7];
        f3    = w[14:12];
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'b0100000 : 7'b0000000;
        imm12 = w[31:20];
        case (kind)
            0: w = {f7, w[24:15], f3, rd, OPC_OP};
            1: begin
                if (f3 == 3'd1) begin
                    imm12 = {7'b0000000, w[24:20]};
                end else if (f3 == 3'd5) begin
                    imm12 = {f7, w[24:20]};
                end
                w = {imm12, w[19:15], f3, rd, OPC_OP_IMM};
            end
            2: w = {w[31:12], rd, OPC_LUI};
            3: w = {w[31:12], rd, OPC_AUIPC};
            4: w = {w[31:12], rd, OPC_JAL};
            5: w = {w[31:20], w[19:15], 3'b000, rd, OPC_JALR};
            6: begin
                case ($urandom % 6)
                    0:       f3 = 3'd0;
                    1:       f3 = 3'd1;
                    2:       f3 = 3'd4;
                    3:       f3 = 3'd5;
                    4:       f3 = 3'd6;
                    default: f3 = 3'd7;
                endcase
                w = {w[31:15], f3, w[11:7], OPC_BRANCH};
            end
            7: w = {7'b0000111, w[24:15], w[13] ? 3'b111 : 3'b101, rd, OPC_OP};
            default: ;
        endcase
        return w;
    endfunction

    // Equal or zero second operands hit beq and czero paths
    function automatic logic [XLEN-1:0] pick_operand(input logic [XLEN-1:0] other);
        case ($urandom % 4)
            0:       pick_operand = other;
            1:       pick_operand = '0;
            default: pick_operand = $urandom;
        endcase
    endfunction

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        out_ready = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        while (issued < NUM_INSTR) begin
            @(posedge clk);
            #1;
            if (offer_taken) begin
                issued   = issued + 1;
                in_valid = 1'b0;
            end
            if (!in_valid && issued < NUM_INSTR && ($urandom % 4 != 0)) begin
                instr    = build_instr($urandom % 10);
                pc       = $urandom & 32'hffff_fffc;
                rs1_data = $urandom;
                rs2_data = pick_operand(rs1_data);
                in_valid = 1'b1;
            end
            if (issued < BP_INSTR) begin
                out_ready = ($urandom % 10) >= 3;
            end else begin
                out_ready = 1'b1;
            end
        end

        // Two stages drain within a few cycles while out_ready stays high
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("instructions accepted but never returned");
        end
    end

    // Sampled mid-cycle, transfers complete on the next rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (!out_ready) begin
                last_low_edge <= edge_count + 1;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                    else abort_run("output transfer with no instruction outstanding");
                check_field("rd_addr", {27'd0, exp_q[0].rd_addr}, {27'd0, rd_addr});
                check_field("rd_write", {31'd0, exp_q[0].rd_write}, {31'd0, rd_write});
                if (exp_q[0].rd_write) begin
                    check_field("rd_data", exp_q[0].rd_data, rd_data);
                end
                check_field("branch_taken", {31'd0, exp_q[0].branch_taken},
                            {31'd0, branch_taken});
                check_field("next_pc", exp_q[0].next_pc, next_pc);
                check_field("illegal", {31'd0, exp_q[0].illegal}, {31'd0, illegal});
                // No stall since acceptance means the fixed latency
                if (last_low_edge <= edge_q[0]) begin
                    check_field("latency", 32'd2, edge_count + 1 - edge_q[0]);
                end
                void'(exp_q.pop_front());
                void'(edge_q.pop_front());
            end
            offer_taken <= in_valid && in_ready;
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_exec(instr, pc, rs1_data, rs2_data));
                edge_q.push_back(edge_count + 1);
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run("timeout, the test did not complete in the allowed time");
    end

endmodule
